// ==== source/video_pkg.sv ====
// raster sizes, palette banks, mode and fetch state enums, video data types
package video_pkg;

	// counter widths
	typedef logic [5:0] hcnt_t;
	typedef logic [2:0] vcnt_t;

	// tiny raster, one strobe per column
	localparam hcnt_t H_TOTAL  = 6'd48;
	localparam hcnt_t H_ACTIVE = 6'd32;
	localparam vcnt_t V_TOTAL  = 3'd6;
	localparam vcnt_t V_ACTIVE = 3'd4;

	// sync placement
	localparam hcnt_t HSYNC_START = 6'd36;
	localparam hcnt_t HSYNC_LEN   = 6'd6;
	localparam vcnt_t VSYNC_LINE  = 3'd5;

	// upper index nibbles per palette bank
	localparam logic [3:0] ZX_PAL     = 4'hF;
	localparam logic [3:0] HC_PAL     = 4'hE;
	localparam logic [3:0] BORDER_PAL = 4'hF;

	// video memory word address width
	localparam int VRAM_AW = 16;

	typedef enum logic [1:0] {
		R_ZX = 2'd0,
		R_HC = 2'd1,
		R_XC = 2'd2,
		R_TX = 2'd3
	} render_mode_t;

	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0,
		FETCH_REQ  = 2'd1,
		FETCH_WAIT = 2'd2
	} fetch_state_t;

	typedef logic [31:0]        vword_t;
	typedef logic [7:0]         pix_index_t;
	typedef logic [VRAM_AW-1:0] vaddr_t;

	// 4 bits per channel
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

endpackage

// ==== source/raster_if.sv ====
// raster strobe and position flags from the timing generator
`timescale 1ns/100ps

interface raster_if;
	logic pix_stb;
	logic pix_start;
	logic hvpix;
	logic frame_reload;

	modport timing (
		output pix_stb, pix_start, hvpix, frame_reload
	);

	modport render (
		input pix_stb, pix_start, hvpix, frame_reload
	);

	// fetcher only needs the frame event
	modport fetch (
		input frame_reload
	);
endinterface

// ==== source/raster_timing.sv ====
// raster timing generator: pixel strobe, column and line counters, syncs
`timescale 1ns/100ps

module raster_timing import video_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     hires,
	raster_if.timing rs,
	output logic     hsync,
	output logic     vsync
);

	hcnt_t hcnt;
	vcnt_t vcnt;
	logic  phase;
	logic  hires_q;
	logic  line_start;
	logic  line_end;
	logic  v_act;
	logic  hs_d;
	logic  vs_d;

	// every clk in hires, every other clk otherwise
	assign rs.pix_stb = hires_q || phase;

	assign line_start = (hcnt == 6'd0);
	assign line_end   = (hcnt == H_TOTAL - 6'd1);
	assign v_act      = (vcnt < V_ACTIVE);

	assign rs.hvpix        = v_act && (hcnt < H_ACTIVE);
	assign rs.pix_start    = rs.pix_stb && line_start && v_act;
	assign rs.frame_reload = rs.pix_stb && line_start && (vcnt == V_TOTAL - 3'd1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase   <= 1'b0;
			hires_q <= 1'b0;
		end else begin
			phase <= ~phase;
			// rate only changes on a frame boundary
			if (rs.frame_reload) begin
				hires_q <= hires;
			end
		end
	end

	// start parked at the top of the last line
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcnt <= 6'd0;
			vcnt <= V_TOTAL - 3'd1;
		end else if (rs.pix_stb) begin
			if (line_end) begin
				hcnt <= 6'd0;
				if (vcnt == V_TOTAL - 3'd1) begin
					vcnt <= 3'd0;
				end else begin
					vcnt <= vcnt + 3'd1;
				end
			end else begin
				hcnt <= hcnt + 6'd1;
			end
		end
	end

	// sampled on the strobe, then one more clk, in step with the pixel path
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hs_d  <= 1'b0;
			vs_d  <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			if (rs.pix_stb) begin
				hs_d <= (hcnt >= HSYNC_START) && (hcnt < HSYNC_START + HSYNC_LEN);
				vs_d <= (vcnt == VSYNC_LINE);
			end
			hsync <= hs_d;
			vsync <= vs_d;
		end
	end

endmodule

// ==== source/video_fetcher.sv ====
// video word fetcher: memory request FSM, two-entry prefetch queue, underrun flag
`timescale 1ns/100ps

module video_fetcher import video_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	raster_if.fetch rs,
	input  vaddr_t  vram_base,
	output logic    mem_req_valid,
	output vaddr_t  mem_req_addr,
	input  logic    mem_req_ready,
	input  logic    mem_rsp_valid,
	input  vword_t  mem_rsp_data,
	output logic    word_valid,
	output vword_t  word,
	input  logic    word_pop,
	output logic    underrun
);

	fetch_state_t state;
	vaddr_t       fetch_addr;
	vaddr_t       next_addr;
	logic         drop;
	vword_t       q_data [2];
	logic         rd_ptr;
	logic         wr_ptr;
	logic [1:0]   count;
	logic [1:0]   count_nxt;
	logic         xfer;
	logic         push;
	logic         pop_ok;
	logic         room;

	assign mem_req_valid = (state == FETCH_REQ);
	assign xfer          = mem_req_valid && mem_req_ready;

	// anything answering a pre-reload request never enters the queue
	assign push   = (state == FETCH_WAIT) && mem_rsp_valid && !drop && !rs.frame_reload;
	assign pop_ok = word_pop && word_valid;

	assign word_valid = (count != 2'd0);
	assign word       = q_data[rd_ptr];

	always_comb begin
		if (rs.frame_reload) begin
			count_nxt = 2'd0;
		end else begin
			count_nxt = count + {1'b0, push} - {1'b0, pop_ok};
		end
	end

	// at most one outstanding, so stored words alone decide
	assign room      = (count_nxt < 2'd2);
	assign next_addr = rs.frame_reload ? vram_base : fetch_addr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= FETCH_IDLE;
			mem_req_addr <= '0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (room) begin
						state        <= FETCH_REQ;
						mem_req_addr <= next_addr;
					end
				end
				FETCH_REQ: begin
					if (xfer) begin
						state <= FETCH_WAIT;
					end
				end
				FETCH_WAIT: begin
					if (mem_rsp_valid) begin
						if (room) begin
							state        <= FETCH_REQ;
							mem_req_addr <= next_addr;
						end else begin
							state <= FETCH_IDLE;
						end
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fetch_addr <= '0;
			drop       <= 1'b0;
		end else begin
			if (rs.frame_reload) begin
				fetch_addr <= vram_base;
			end else if (xfer && !drop) begin
				fetch_addr <= fetch_addr + 1'b1;
			end
			// old request still pending or in flight
			if (rs.frame_reload && ((state == FETCH_REQ) ||
					((state == FETCH_WAIT) && !mem_rsp_valid))) begin
				drop <= 1'b1;
			end else if ((state == FETCH_WAIT) && mem_rsp_valid) begin
				drop <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count    <= 2'd0;
			rd_ptr   <= 1'b0;
			wr_ptr   <= 1'b0;
			underrun <= 1'b0;
		end else begin
			count <= count_nxt;
			if (rs.frame_reload) begin
				rd_ptr <= 1'b0;
				wr_ptr <= 1'b0;
			end else begin
				if (push) begin
					wr_ptr <= ~wr_ptr;
				end
				if (pop_ok) begin
					rd_ptr <= ~rd_ptr;
				end
			end
			// sticky until reset
			if (word_pop && !word_valid) begin
				underrun <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_data[wr_ptr] <= mem_rsp_data;
		end
	end

endmodule

// ==== source/video_render.sv ====
// pixel renderer: word register, ZX/HC/XC/TX decoders, border mix
`timescale 1ns/100ps

module video_render import video_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	raster_if.render     rs,
	input  render_mode_t render_mode,
	input  logic [3:0]   border,
	input  logic         word_valid,
	input  vword_t       word,
	output logic         word_pop,
	output pix_index_t   pix_index,
	output logic         index_valid,
	output logic         index_active
);

	render_mode_t mode_q;
	logic [3:0]   cnt;
	logic [3:0]   pix_n;
	logic         act_stb;
	logic         word_start;
	logic         act_d;
	vword_t       data_q;
	vword_t       cur;
	logic         zx_dot;
	logic [7:0]   zx_attr;
	logic [3:0]   hc_dot;
	logic [7:0]   xc_dot;
	pix_index_t   dec_index;

	assign act_stb = rs.pix_stb && rs.hvpix;
	assign pix_n   = rs.pix_start ? 4'd0 : cnt;

	// 16, 8 or 4 pixels per word
	always_comb begin
		case (mode_q)
			R_HC:    word_start = (pix_n[2:0] == 3'd0);
			R_XC:    word_start = (pix_n[1:0] == 2'd0);
			default: word_start = (pix_n == 4'd0);
		endcase
	end

	// pix_start clears pix_n, so a line always opens with a pop
	assign word_pop = act_stb && word_start;

	// on underrun the old word stays in use
	assign cur = (word_pop && word_valid) ? word : data_q;

	// zx: bit 15 is the leftmost dot
	assign zx_dot  = cur[~pix_n];
	assign zx_attr = pix_n[3] ? cur[31:24] : cur[23:16];

	// hc: high nibble first within each byte
	assign hc_dot = cur[{pix_n[2:1], ~pix_n[0], 2'b00} +: 4];
	assign xc_dot = cur[{pix_n[1:0], 3'b000} +: 8];

	always_comb begin
		case (mode_q)
			R_ZX:    dec_index = {ZX_PAL, zx_attr[6], zx_dot ? zx_attr[2:0] : zx_attr[5:3]};
			R_HC:    dec_index = {HC_PAL, hc_dot};
			R_XC:    dec_index = xc_dot;
			default: dec_index = {HC_PAL, zx_dot ? zx_attr[3:0] : zx_attr[7:4]};
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode_q       <= R_ZX;
			cnt          <= 4'd0;
			index_valid  <= 1'b0;
			act_d        <= 1'b0;
			index_active <= 1'b0;
		end else begin
			if (rs.frame_reload) begin
				mode_q <= render_mode;
			end
			if (act_stb) begin
				cnt <= pix_n + 4'd1;
			end
			index_valid <= rs.pix_stb;
			if (rs.pix_stb) begin
				act_d <= rs.hvpix;
			end
			// second stage lines up with the palette output
			index_active <= act_d;
		end
	end

	always_ff @(posedge clk) begin
		if (word_pop && word_valid) begin
			data_q <= word;
		end
		if (rs.pix_stb) begin
			pix_index <= rs.hvpix ? dec_index : {BORDER_PAL, border};
		end
	end

endmodule

// ==== source/video_palette.sv ====
// writable 256-entry palette with registered RGB output
`timescale 1ns/100ps

module video_palette import video_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  pix_index_t pix_index,
	input  logic       index_valid,
	input  logic       pal_we,
	input  pix_index_t pal_addr,
	input  rgb_t       pal_data,
	output rgb_t       pix_rgb,
	output logic       pix_valid
);

	rgb_t pal_mem [256];

	// cpu side write port
	always_ff @(posedge clk) begin
		if (pal_we) begin
			pal_mem[pal_addr] <= pal_data;
		end
	end

	// lookup only on a fresh index
	always_ff @(posedge clk) begin
		if (index_valid) begin
			pix_rgb <= pal_mem[pix_index];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= index_valid;
		end
	end

endmodule

// ==== source/video_out.sv ====
// video output top: timing, fetcher, renderer and palette
`timescale 1ns/100ps

module video_out import video_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       hires,
	input  logic [1:0] render_mode,
	input  logic [3:0] border,
	input  vaddr_t     vram_base,
	output logic       mem_req_valid,
	output vaddr_t     mem_req_addr,
	input  logic       mem_req_ready,
	input  logic       mem_rsp_valid,
	input  vword_t     mem_rsp_data,
	input  logic       pal_we,
	input  pix_index_t pal_addr,
	input  rgb_t       pal_data,
	output rgb_t       pix_rgb,
	output logic       pix_valid,
	output logic       pix_active,
	output logic       hsync,
	output logic       vsync,
	output logic       underrun
);

	raster_if rs ();

	logic       word_valid;
	vword_t     word;
	logic       word_pop;
	pix_index_t pix_index;
	logic       index_valid;

	raster_timing i_raster_timing (
		.clk    (clk),
		.arst_n (arst_n),
		.hires  (hires),
		.rs     (rs.timing),
		.hsync  (hsync),
		.vsync  (vsync)
	);

	video_fetcher i_video_fetcher (
		.clk           (clk),
		.arst_n        (arst_n),
		.rs            (rs.fetch),
		.vram_base     (vram_base),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_ready (mem_req_ready),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data),
		.word_valid    (word_valid),
		.word          (word),
		.word_pop      (word_pop),
		.underrun      (underrun)
	);

	video_render i_video_render (
		.clk          (clk),
		.arst_n       (arst_n),
		.rs           (rs.render),
		.render_mode  (render_mode_t'(render_mode)),
		.border       (border),
		.word_valid   (word_valid),
		.word         (word),
		.word_pop     (word_pop),
		.pix_index    (pix_index),
		.index_valid  (index_valid),
		.index_active (pix_active)
	);

	video_palette i_video_palette (
		.clk         (clk),
		.arst_n      (arst_n),
		.pix_index   (pix_index),
		.index_valid (index_valid),
		.pal_we      (pal_we),
		.pal_addr    (pal_addr),
		.pal_data    (pal_data),
		.pix_rgb     (pix_rgb),
		.pix_valid   (pix_valid)
	);

endmodule

// ==== tb/tb_video_checks.svh ====
// pixel reference model and typed compare tasks for the video testbench
`ifndef TB_VIDEO_CHECKS_SVH
`define TB_VIDEO_CHECKS_SVH

// palette index of one active pixel, taken from the testbench copy of video memory
function automatic pix_index_t expected_index(render_mode_t mode, vaddr_t base, int line,
		int col);
	int         words_per_line;
	int         pix_per_word;
	int         k;
	logic [7:0] addr;
	vword_t     data;
	logic       dot;
	logic [7:0] attr;
	case (mode)
		R_HC:    words_per_line = 4;
		R_XC:    words_per_line = 8;
		default: words_per_line = 2;
	endcase
	pix_per_word = 32 / words_per_line;
	k            = col % pix_per_word;
	// words run on from line to line in address order
	addr = 8'(int'(base) + line * words_per_line + col / pix_per_word);
	data = vram[addr];
	dot  = data[15 - k];
	attr = (k < 8) ? data[23:16] : data[31:24];
	case (mode)
		R_ZX:    return {ZX_PAL, attr[6], dot ? attr[2:0] : attr[5:3]};
		// even pixel takes the high nibble of its byte
		R_HC:    return {HC_PAL, data[(k / 2) * 8 + ((k % 2 == 0) ? 4 : 0) +: 4]};
		R_XC:    return data[k * 8 +: 8];
		default: return {HC_PAL, dot ? attr[3:0] : attr[7:4]};
	endcase
endfunction

task automatic check_rgb(string name, rgb_t expected, rgb_t actual);
	if (actual !== expected) begin
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		abort_run();
	end
endtask

task automatic check_flag(string name, logic expected, logic actual);
	if (actual !== expected) begin
		$display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
		abort_run();
	end
endtask

`endif

// ==== tb/tb_video_out.sv ====
// testbench for video_out: clock, reset, video memory model, beat collector, directed tests
`timescale 1ns/100ps

module tb_video_out import video_pkg::*; ();

	localparam int FRAME_BEATS = int'(H_TOTAL) * int'(V_TOTAL);
	// all tests together take about 13000 cycles
	localparam int MAX_CYCLES  = 20000;

	logic       clk;
	logic       arst_n;
	logic       hires;
	logic [1:0] render_mode;
	logic [3:0] border;
	vaddr_t     vram_base;
	logic       mem_req_valid;
	vaddr_t     mem_req_addr;
	logic       mem_req_ready;
	logic       mem_rsp_valid;
	vword_t     mem_rsp_data;
	logic       pal_we;
	pix_index_t pal_addr;
	rgb_t       pal_data;
	rgb_t       pix_rgb;
	logic       pix_valid;
	logic       pix_active;
	logic       hsync;
	logic       vsync;
	logic       underrun;

	integer seed = 44098;
	int     cycles = 0;
	vword_t vram [256];
	rgb_t   pal_ref [256];
	rgb_t   beat_rgb [$];
	logic   beat_act [$];
	logic   beat_hs [$];
	logic   beat_vs [$];
	// 0 ready always, 1 random gaps, 2 held low
	int     ready_mode;
	int     rsp_delay_max;

	video_out i_video_out (
		.clk           (clk),
		.arst_n        (arst_n),
		.hires         (hires),
		.render_mode   (render_mode),
		.border        (border),
		.vram_base     (vram_base),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_ready (mem_req_ready),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data),
		.pal_we        (pal_we),
		.pal_addr      (pal_addr),
		.pal_data      (pal_data),
		.pix_rgb       (pix_rgb),
		.pix_valid     (pix_valid),
		.pix_active    (pix_active),
		.hsync         (hsync),
		.vsync         (vsync),
		.underrun      (underrun)
	);

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after an error");
	endtask

	`include "tb_video_checks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	// every output beat, in raster order from the first strobe after reset
	always @(posedge clk) begin
		if (pix_valid) begin
			beat_rgb.push_back(pix_rgb);
			beat_act.push_back(pix_active);
			beat_hs.push_back(hsync);
			beat_vs.push_back(vsync);
		end
	end

	// one request in flight at most, answered after 1 to rsp_delay_max cycles
	initial begin : memory_model
		logic [31:0] rnd;
		logic        xfer;
		vaddr_t      req_addr;
		vaddr_t      rsp_addr;
		int          wait_cnt;
		wait_cnt = 0;
		rsp_addr = '0;
		forever begin
			@(posedge clk);
			xfer     = mem_req_valid && mem_req_ready;
			req_addr = mem_req_addr;
			#10;
			rnd           = $random(seed);
			mem_rsp_valid = 1'b0;
			if (xfer) begin
				rsp_addr = req_addr;
				wait_cnt = 1 + int'(rnd[15:8]) % rsp_delay_max;
			end
			if (wait_cnt > 0) begin
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					mem_rsp_valid = 1'b1;
					mem_rsp_data  = vram[rsp_addr[7:0]];
				end
			end
			case (ready_mode)
				1:       mem_req_ready = rnd[0];
				2:       mem_req_ready = 1'b0;
				default: mem_req_ready = 1'b1;
			endcase
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic wait_beats(int count);
		while (beat_rgb.size() < count) begin
			next_cycle();
		end
	endtask

	task automatic write_palette(pix_index_t addr, rgb_t value);
		pal_we        = 1'b1;
		pal_addr      = addr;
		pal_data      = value;
		pal_ref[addr] = value;
		next_cycle();
		pal_we = 1'b0;
	endtask

	task automatic fill_palette();
		logic [31:0] rnd;
		for (int i = 0; i < 256; i++) begin
			rnd = $random(seed);
			write_palette(8'(i), rnd[11:0]);
		end
	endtask

	// skips to a frame whose reload saw the current inputs, then checks every beat
	task automatic check_next_frame();
		int   start;
		int   line;
		int   col;
		logic exp_act;
		logic exp_hs;
		logic exp_vs;
		rgb_t exp_rgb;
		start = (beat_rgb.size() / FRAME_BEATS + 2) * FRAME_BEATS;
		wait_beats(start + FRAME_BEATS);
		for (int offs = 0; offs < FRAME_BEATS; offs++) begin
			// beat 0 of a frame is column 0 of the last line
			line    = (offs / int'(H_TOTAL) + int'(V_TOTAL) - 1) % int'(V_TOTAL);
			col     = offs % int'(H_TOTAL);
			exp_act = (line < int'(V_ACTIVE)) && (col < int'(H_ACTIVE));
			exp_hs  = (col >= int'(HSYNC_START)) &&
				(col < int'(HSYNC_START) + int'(HSYNC_LEN));
			exp_vs  = (line == int'(VSYNC_LINE));
			if (exp_act) begin
				exp_rgb = pal_ref[expected_index(render_mode_t'(render_mode), vram_base,
					line, col)];
			end else begin
				exp_rgb = pal_ref[{BORDER_PAL, border}];
			end
			check_flag($sformatf("pix_active line %0d col %0d", line, col), exp_act,
				beat_act[start + offs]);
			check_flag($sformatf("hsync line %0d col %0d", line, col), exp_hs,
				beat_hs[start + offs]);
			check_flag($sformatf("vsync line %0d col %0d", line, col), exp_vs,
				beat_vs[start + offs]);
			check_rgb($sformatf("pix_rgb line %0d col %0d", line, col), exp_rgb,
				beat_rgb[start + offs]);
		end
	endtask

	task automatic border_and_blanking();
		fill_palette();
		hires       = 1'b0;
		render_mode = R_ZX;
		border      = 4'h5;
		vram_base   = 16'h0000;
		check_next_frame();
	endtask

	task automatic zx_lowres_frame();
		border    = 4'hA;
		vram_base = 16'h0030;
		check_next_frame();
		check_flag("underrun", 1'b0, underrun);
	endtask

	task automatic hc_xc_hires_frames();
		hires       = 1'b1;
		render_mode = R_HC;
		vram_base   = 16'h0080;
		check_next_frame();
		// 32 words per frame, wraps past the top of the model
		render_mode = R_XC;
		vram_base   = 16'h00F0;
		check_next_frame();
		check_flag("underrun", 1'b0, underrun);
	endtask

	task automatic tx_palette_rewrite();
		logic [11:0] old;
		hires       = 1'b0;
		render_mode = R_TX;
		vram_base   = 16'h0010;
		check_next_frame();
		// inverted entries, so every colour of the bank changes
		for (int i = 0; i < 16; i++) begin
			old = pal_ref[{HC_PAL, 4'(i)}];
			write_palette({HC_PAL, 4'(i)}, ~old);
		end
		check_next_frame();
	endtask

	task automatic memory_backpressure();
		int start;
		render_mode   = R_ZX;
		vram_base     = 16'h0050;
		ready_mode    = 1;
		rsp_delay_max = 3;
		check_next_frame();
		check_flag("underrun", 1'b0, underrun);
		ready_mode = 2;
		start      = (beat_rgb.size() / FRAME_BEATS + 2) * FRAME_BEATS;
		// reload empties the queue, so line 0 starves
		wait_beats(start + 2 * int'(H_TOTAL));
		check_flag("underrun", 1'b1, underrun);
		ready_mode = 0;
	endtask

	initial begin
		arst_n        = 1'b0;
		hires         = 1'b0;
		render_mode   = R_ZX;
		border        = 4'h0;
		vram_base     = '0;
		mem_req_ready = 1'b1;
		mem_rsp_valid = 1'b0;
		mem_rsp_data  = '0;
		pal_we        = 1'b0;
		pal_addr      = '0;
		pal_data      = '0;
		ready_mode    = 0;
		rsp_delay_max = 1;
		for (int i = 0; i < 256; i++) begin
			vram[i] = $random(seed);
		end
		repeat (5) @(posedge clk);
		#10;
		arst_n = 1'b1;
		border_and_blanking();
		zx_lowres_frame();
		hc_xc_hires_frames();
		tx_palette_rewrite();
		memory_backpressure();
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+tb
source/video_pkg.sv
source/raster_if.sv
source/raster_timing.sv
source/video_fetcher.sv
source/video_render.sv
source/video_palette.sv
source/video_out.sv
tb/tb_video_out.sv

// ==== run.sh ====
#!/bin/sh
# build and run the video_out testbench with Verilator
verilator --binary --timing -Wno-fatal --top-module tb_video_out -f files.f || exit 1
out=$(./obj_dir/Vtb_video_out)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "run passed" || { echo "run failed"; exit 1; }
